//--- tb.f
+incdir+common
common/soc_pkg.sv
common/soc_bus_if.sv
logic/bus_split.sv
int_mem/boot_copier.sv
int_mem/int_mem.sv
logic/timer_regs.sv
logic/soc_top.sv
dv/tb_soc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_soc \
   -o tb_soc_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_soc_sim > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0

//--- dv/tb_soc.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc
   import soc_pkg::*;
();

   localparam logic [1:0] OP_RD   = 2'd0;
   localparam logic [1:0] OP_WR   = 2'd1;
   localparam logic [1:0] OP_IDLE = 2'd2;
   localparam logic [1:0] OP_IRQ  = 2'd3;

   // one stimulus row, exp is used by timer reads and irq checks
   typedef struct packed {
      logic [1:0]             op;
      logic [`SOC_ADDR_W-1:0] addr;
      logic [`SOC_DATA_W-1:0] wdata;
      logic [`SOC_STRB_W-1:0] wstrb;
      logic [`SOC_DATA_W-1:0] exp;
   } row_t;

   logic                       clk_i;
   logic                       rst_n_i;
   logic                       bus_valid_i;
   logic [`SOC_ADDR_W-1:0]     bus_addr_i;
   logic [`SOC_DATA_W-1:0]     bus_wdata_i;
   logic [`SOC_STRB_W-1:0]     bus_wstrb_i;
   logic                       bus_ready_o;
   logic [`SOC_DATA_W-1:0]     bus_rdata_o;
   logic                       bus_rvalid_o;
   logic                       rom_r_valid_o;
   logic [`SOC_ROM_ADDR_W-1:0] rom_r_addr_o;
   logic [`SOC_DATA_W-1:0]     rom_r_rdata_i;
   logic                       boot_done_o;
   logic                       timer_irq_o;

   logic [`SOC_DATA_W-1:0]     rom_mem [`SOC_BOOT_WORDS];
   logic [`SOC_DATA_W-1:0]     mem_model [`SOC_SRAM_WORDS];
   logic [31:0]                lfsr;
   row_t                       rows [$];
   logic [`SOC_DATA_W-1:0]     exp_q [$];
   logic [`SOC_DATA_W-1:0]     exp_word;
   logic                       rd_acc_prev;
   logic                       rom_req;
   logic [`SOC_ROM_ADDR_W-1:0] rom_req_addr;
   int                         last_stalls;
   int                         cycle_cnt;
   int                         timeout_limit;

   soc_top dut_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .bus_valid_i  (bus_valid_i),
      .bus_addr_i   (bus_addr_i),
      .bus_wdata_i  (bus_wdata_i),
      .bus_wstrb_i  (bus_wstrb_i),
      .bus_ready_o  (bus_ready_o),
      .bus_rdata_o  (bus_rdata_o),
      .bus_rvalid_o (bus_rvalid_o),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .boot_done_o  (boot_done_o),
      .timer_irq_o  (timer_irq_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [`SOC_ADDR_W-1:0] mem_addr(input int w);
      return `SOC_ADDR_W'(w * 4);
   endfunction

   function automatic logic [`SOC_ADDR_W-1:0] tmr_addr(input logic [1:0] idx);
      return {1'b1, 11'd0, idx, 2'b00};
   endfunction

   task automatic fill_rom();
      logic [`SOC_DATA_W-1:0] w;
      lfsr = 32'h035c2a0c;
      for (int k = 0; k < `SOC_BOOT_WORDS; k++) begin
         w = '0;
         for (int b = 0; b < `SOC_DATA_W; b++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[`SOC_DATA_W-2:0], lfsr[0]};
         end
         rom_mem[k] = w;
      end
   endtask

   task automatic add_row(input logic [1:0] op, input logic [`SOC_ADDR_W-1:0] addr,
                          input logic [`SOC_DATA_W-1:0] wdata,
                          input logic [`SOC_STRB_W-1:0] wstrb,
                          input logic [`SOC_DATA_W-1:0] exp);
      row_t r;
      r.op    = op;
      r.addr  = addr;
      r.wdata = wdata;
      r.wstrb = wstrb;
      r.exp   = exp;
      rows.push_back(r);
   endtask

   task automatic build_table();
      // first read lands during boot and has to stall
      add_row(OP_RD, mem_addr(0), 0, 4'h0, 0);
      for (int k = 0; k < `SOC_BOOT_WORDS; k++) begin
         add_row(OP_RD, mem_addr(k), 0, 4'h0, 0);
      end
      // partial strobes over boot words and a fresh word
      add_row(OP_WR, mem_addr(3), 32'ha1b2c3d4, 4'b0101, 0);
      add_row(OP_RD, mem_addr(3), 0, 4'h0, 0);
      add_row(OP_WR, mem_addr(7), 32'h5a000000, 4'b1000, 0);
      add_row(OP_RD, mem_addr(7), 0, 4'h0, 0);
      add_row(OP_WR, mem_addr(16), 32'h12345678, 4'b1111, 0);
      add_row(OP_WR, mem_addr(16), 32'hffffeeff, 4'b0010, 0);
      add_row(OP_RD, mem_addr(16), 0, 4'h0, 0);
      // timer runs down from 20 and flags expiry
      add_row(OP_WR, tmr_addr(LOAD), 20, 4'b1111, 0);
      add_row(OP_IDLE, 0, 30, 4'h0, 0);
      add_row(OP_RD, tmr_addr(COUNT), 0, 4'h0, 0);
      add_row(OP_RD, tmr_addr(STATUS), 0, 4'h0, 1);
      add_row(OP_IRQ, 0, 0, 4'h0, 1);
      add_row(OP_WR, tmr_addr(STATUS), 1, 4'b0001, 0);
      add_row(OP_RD, tmr_addr(STATUS), 0, 4'h0, 0);
      add_row(OP_IRQ, 0, 0, 4'h0, 0);
      add_row(OP_RD, tmr_addr(2'd3), 0, 4'h0, 0);
      // back to back, memory and timer interleaved
      add_row(OP_RD, mem_addr(1), 0, 4'h0, 0);
      add_row(OP_RD, tmr_addr(LOAD), 0, 4'h0, 20);
      add_row(OP_RD, mem_addr(3), 0, 4'h0, 0);
      add_row(OP_RD, tmr_addr(COUNT), 0, 4'h0, 0);
      add_row(OP_RD, mem_addr(16), 0, 4'h0, 0);
      add_row(OP_RD, tmr_addr(2'd3), 0, 4'h0, 0);
      add_row(OP_RD, mem_addr(15), 0, 4'h0, 0);
      add_row(OP_RD, tmr_addr(STATUS), 0, 4'h0, 0);
   endtask

   // called at posedge + 2 ns, returns at the next posedge + 2 ns
   task automatic run_row(input row_t r);
      logic [`SOC_SRAM_WORDS_W-1:0] w;
      w = r.addr[`SOC_SRAM_WORDS_W+1:2];
      last_stalls = 0;
      if (r.op == OP_RD || r.op == OP_WR) begin
         bus_valid_i = 1'b1;
         bus_addr_i  = r.addr;
         bus_wdata_i = r.wdata;
         bus_wstrb_i = (r.op == OP_WR) ? r.wstrb : '0;
         @(negedge clk_i);
         while (bus_ready_o !== 1'b1) begin
            // only memory may hold off, and only during boot
            assert (!r.addr[15] && boot_done_o === 1'b0)
               else report_failure("request stalled although its slave should be ready");
            last_stalls++;
            @(negedge clk_i);
         end
         assert (r.addr[15] || boot_done_o === 1'b1)
            else report_failure($sformatf("Error: bus_ready_o expected %h got %h", 1'b0,
                                          bus_ready_o));
         @(posedge clk_i);
         if (r.op == OP_WR && !r.addr[15]) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
               if (r.wstrb[b]) begin
                  mem_model[w][8*b +: 8] = r.wdata[8*b +: 8];
               end
            end
         end else if (r.op == OP_RD) begin
            exp_q.push_back(r.addr[15] ? r.exp : mem_model[w]);
         end
         #2;
         bus_valid_i = 1'b0;
      end else if (r.op == OP_IDLE) begin
         bus_valid_i = 1'b0;
         repeat (r.wdata) @(posedge clk_i);
         #2;
      end else begin
         bus_valid_i = 1'b0;
         @(negedge clk_i);
         assert (timer_irq_o === r.exp[0])
            else report_failure($sformatf("Error: timer_irq_o expected %h got %h", r.exp[0],
                                          timer_irq_o));
         @(posedge clk_i);
         #2;
      end
   endtask

   // rom answers one cycle after each read
   always begin
      @(negedge clk_i);
      rom_req      = rom_r_valid_o;
      rom_req_addr = rom_r_addr_o;
      @(posedge clk_i);
      #2;
      if (rom_req === 1'b1) begin
         rom_r_rdata_i = rom_mem[rom_req_addr];
      end
   end

   // every response exactly one cycle after its read, in order
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         assert (bus_rvalid_o === rd_acc_prev)
            else report_failure($sformatf("Error: bus_rvalid_o expected %h got %h",
                                          rd_acc_prev, bus_rvalid_o));
         if (bus_rvalid_o === 1'b1) begin
            assert (exp_q.size() != 0)
               else report_failure("read response arrived with no read outstanding");
            exp_word = exp_q.pop_front();
            assert (bus_rdata_o === exp_word)
               else report_failure($sformatf("Error: bus_rdata_o expected %h got %h",
                                             exp_word, bus_rdata_o));
         end
      end
      rd_acc_prev = (bus_valid_i === 1'b1) && (bus_ready_o === 1'b1) &&
                    (bus_wstrb_i === '0);
   end

   always @(posedge clk_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > timeout_limit) begin
         report_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                  timeout_limit));
      end
   end

   initial begin
      rst_n_i       = 1'b0;
      bus_valid_i   = 1'b0;
      bus_addr_i    = '0;
      bus_wdata_i   = '0;
      bus_wstrb_i   = '0;
      rom_r_rdata_i = '0;
      rd_acc_prev   = 1'b0;
      cycle_cnt     = 0;
      last_stalls   = 0;
      fill_rom();
      for (int k = 0; k < `SOC_SRAM_WORDS; k++) begin
         mem_model[k] = (k < `SOC_BOOT_WORDS) ? rom_mem[k] : '0;
      end
      build_table();
      timeout_limit = 40 + 8 * rows.size();

      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      assert ({bus_ready_o, bus_rvalid_o, rom_r_valid_o, boot_done_o, timer_irq_o} === 5'b0)
         else report_failure($sformatf(
            "Error: {bus_ready_o,bus_rvalid_o,rom_r_valid_o,boot_done_o,timer_irq_o} expected %h got %h",
            5'h0, {bus_ready_o, bus_rvalid_o, rom_r_valid_o, boot_done_o, timer_irq_o}));
      @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;

      foreach (rows[i]) begin
         run_row(rows[i]);
         if (i == 0) begin
            assert (last_stalls > 0)
               else report_failure("first memory read was not held off during boot");
         end
      end

      // let the last response come back
      while (exp_q.size() != 0) @(negedge clk_i);
      @(negedge clk_i);

      $display("All checks passed");
      $finish;
   end

endmodule

//--- logic/soc_top.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top (
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   // external bus master
   input  logic                       bus_valid_i,
   input  logic [`SOC_ADDR_W-1:0]     bus_addr_i,
   input  logic [`SOC_DATA_W-1:0]     bus_wdata_i,
   input  logic [`SOC_STRB_W-1:0]     bus_wstrb_i,
   output logic                       bus_ready_o,
   output logic [`SOC_DATA_W-1:0]     bus_rdata_o,
   output logic                       bus_rvalid_o,

   // boot rom
   output logic                       rom_r_valid_o,
   output logic [`SOC_ROM_ADDR_W-1:0] rom_r_addr_o,
   input  logic [`SOC_DATA_W-1:0]     rom_r_rdata_i,

   output logic                       boot_done_o,
   output logic                       timer_irq_o
);

   soc_bus_if cpu_bus ();
   soc_bus_if mem_bus ();
   soc_bus_if tmr_bus ();

   // plain ports onto the master side bus
   assign cpu_bus.valid    = bus_valid_i;
   assign cpu_bus.addr.raw = bus_addr_i;
   assign cpu_bus.wdata    = bus_wdata_i;
   assign cpu_bus.wstrb    = bus_wstrb_i;
   assign bus_ready_o      = cpu_bus.ready;
   assign bus_rdata_o      = cpu_bus.rdata;
   assign bus_rvalid_o     = cpu_bus.rvalid;

   // memory or timer
   bus_split split0 (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .m_bus  (cpu_bus.slave),
      .mem_bus(mem_bus.master),
      .tmr_bus(tmr_bus.master)
   );

   int_mem int_mem0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .bus          (mem_bus.slave),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .boot_done_o  (boot_done_o)
   );

   timer_regs timer0 (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .bus    (tmr_bus.slave),
      .irq_o  (timer_irq_o)
   );

endmodule

//--- logic/timer_regs.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module timer_regs
   import soc_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,
   soc_bus_if.slave bus,
   output logic     irq_o
);

   timer_reg_e             idx;
   logic                   wr;
   logic                   rd;
   logic                   load_wr;
   logic [`SOC_DATA_W-1:0] load_nxt;
   logic [`SOC_DATA_W-1:0] load_q;
   logic [`SOC_DATA_W-1:0] count_q;
   logic                   expired_q;
   logic [`SOC_DATA_W-1:0] rdata_q;
   logic                   rvalid_q;

   // never stalls
   assign bus.ready = 1'b1;

   assign idx     = timer_reg_e'(bus.addr.f.word[1:0]);
   assign wr      = bus.valid & |bus.wstrb;
   assign rd      = bus.valid & ~|bus.wstrb;
   assign load_wr = wr && idx == LOAD;

   // strobed bytes of LOAD replaced
   always_comb begin
      load_nxt = load_q;
      for (int b = 0; b < `SOC_STRB_W; b++) begin
         if (bus.wstrb[b]) begin
            load_nxt[8*b +: 8] = bus.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         load_q    <= '0;
         count_q   <= '0;
         expired_q <= 1'b0;
      end else begin
         if (load_wr) begin
            load_q  <= load_nxt;
            count_q <= load_nxt;
         end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
         end
         // sticky, expiry wins over a clear in the same cycle
         if (!load_wr && count_q == `SOC_DATA_W'(1)) begin
            expired_q <= 1'b1;
         end else if (wr && idx == STATUS && bus.wstrb[0] && bus.wdata[0]) begin
            expired_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd;
      end
      if (rd) begin
         case (idx)
            LOAD:    rdata_q <= load_q;
            COUNT:   rdata_q <= count_q;
            STATUS:  rdata_q <= {{(`SOC_DATA_W - 1){1'b0}}, expired_q};
            default: rdata_q <= '0;
         endcase
      end
   end

   assign bus.rdata  = rdata_q;
   assign bus.rvalid = rvalid_q;
   assign irq_o      = expired_q;

endmodule

//--- int_mem/int_mem.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module int_mem (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   soc_bus_if.slave                   bus,
   output logic                       rom_r_valid_o,
   output logic [`SOC_ROM_ADDR_W-1:0] rom_r_addr_o,
   input  logic [`SOC_DATA_W-1:0]     rom_r_rdata_i,
   output logic                       boot_done_o
);

   logic [`SOC_DATA_W-1:0]      sram_q [`SOC_SRAM_WORDS];
   logic                        cp_wr_en;
   logic [`SOC_SRAM_WORDS_W-1:0] cp_wr_addr;
   logic [`SOC_DATA_W-1:0]      cp_wr_data;
   logic                        boot_done;
   logic                        acc;
   logic [`SOC_STRB_W-1:0]      we;
   logic [`SOC_SRAM_WORDS_W-1:0] ram_addr;
   logic [`SOC_DATA_W-1:0]      ram_wdata;
   logic [`SOC_DATA_W-1:0]      rdata_q;
   logic                        rvalid_q;

   boot_copier copier0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .wr_en_o      (cp_wr_en),
      .wr_addr_o    (cp_wr_addr),
      .wr_data_o    (cp_wr_data),
      .boot_done_o  (boot_done)
   );

   // bus is held off until the image is in place
   assign bus.ready   = boot_done;
   assign boot_done_o = boot_done;
   assign acc         = bus.valid & boot_done;

   // sram port owned by the copier during boot, by the bus afterwards
   always_comb begin
      if (!boot_done) begin
         we        = {`SOC_STRB_W{cp_wr_en}};
         ram_addr  = cp_wr_addr;
         ram_wdata = cp_wr_data;
      end else begin
         we        = acc ? bus.wstrb : '0;
         ram_addr  = bus.addr.f.word[`SOC_SRAM_WORDS_W-1:0];
         ram_wdata = bus.wdata;
      end
   end

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < `SOC_STRB_W; b++) begin
         if (we[b]) begin
            sram_q[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];
         end
      end
      if (acc && ~|bus.wstrb) begin
         rdata_q <= sram_q[ram_addr];
      end
   end

   // reads answer one cycle after acceptance, writes never do
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= acc & ~|bus.wstrb;
      end
   end

   assign bus.rdata  = rdata_q;
   assign bus.rvalid = rvalid_q;

   // copier writes and bus service never overlap
   a_ready_after_boot : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      bus.ready |-> !cp_wr_en
   ) else $error("bus ready while the copier still writes the sram");

endmodule

//--- int_mem/boot_copier.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module boot_copier (
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   output logic                         rom_r_valid_o,
   output logic [`SOC_ROM_ADDR_W-1:0]   rom_r_addr_o,
   input  logic [`SOC_DATA_W-1:0]       rom_r_rdata_i,
   output logic                         wr_en_o,
   output logic [`SOC_SRAM_WORDS_W-1:0] wr_addr_o,
   output logic [`SOC_DATA_W-1:0]       wr_data_o,
   output logic                         boot_done_o
);

   localparam int unsigned LAST_WORD = `SOC_BOOT_WORDS - 1;

   logic                         rd_active_q;
   logic                         rd_done_q;
   logic [`SOC_ROM_ADDR_W-1:0]   rd_cnt_q;
   logic                         wr_en_q;
   logic [`SOC_SRAM_WORDS_W-1:0] wr_addr_q;
   logic                         boot_done_q;

   // read side, one rom word per cycle once out of reset
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_active_q <= 1'b0;
         rd_done_q   <= 1'b0;
         rd_cnt_q    <= '0;
      end else if (rd_active_q) begin
         rd_cnt_q <= rd_cnt_q + 1'b1;
         if (rd_cnt_q == LAST_WORD[`SOC_ROM_ADDR_W-1:0]) begin
            rd_active_q <= 1'b0;
            rd_done_q   <= 1'b1;
         end
      end else if (!rd_done_q) begin
         rd_active_q <= 1'b1;
      end
   end

   assign rom_r_valid_o = rd_active_q;
   assign rom_r_addr_o  = rd_cnt_q;

   // write side trails by one cycle, rom data arrives then
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_en_q     <= 1'b0;
         wr_addr_q   <= '0;
         boot_done_q <= 1'b0;
      end else begin
         wr_en_q   <= rd_active_q;
         wr_addr_q <= {{(`SOC_SRAM_WORDS_W - `SOC_ROM_ADDR_W){1'b0}}, rd_cnt_q};
         if (wr_en_q && wr_addr_q == LAST_WORD[`SOC_SRAM_WORDS_W-1:0]) begin
            boot_done_q <= 1'b1;
         end
      end
   end

   assign wr_en_o     = wr_en_q;
   assign wr_addr_o   = wr_addr_q;
   assign wr_data_o   = rom_r_rdata_i;
   assign boot_done_o = boot_done_q;

   a_no_rom_after_done : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      boot_done_q |=> !rom_r_valid_o && !wr_en_q
   ) else $error("rom read or sram write after boot done");

endmodule

//--- logic/bus_split.sv
`timescale 1ns/1ps

module bus_split (
   input logic        clk_i,
   input logic        rst_n_i,
   soc_bus_if.slave   m_bus,
   soc_bus_if.master  mem_bus,
   soc_bus_if.master  tmr_bus
);

   logic sel;
   logic rd_acc;
   logic rd_sel_q;

   // top address bit picks the slave
   assign sel = m_bus.addr.f.sel;

   // request goes to both, valid only to the chosen one
   assign mem_bus.valid = m_bus.valid & ~sel;
   assign mem_bus.addr  = m_bus.addr;
   assign mem_bus.wdata = m_bus.wdata;
   assign mem_bus.wstrb = m_bus.wstrb;

   assign tmr_bus.valid = m_bus.valid & sel;
   assign tmr_bus.addr  = m_bus.addr;
   assign tmr_bus.wdata = m_bus.wdata;
   assign tmr_bus.wstrb = m_bus.wstrb;

   // ready comes back from the addressed slave, no added cycle
   assign m_bus.ready = sel ? tmr_bus.ready : mem_bus.ready;

   // read accepted this cycle
   assign rd_acc = m_bus.valid & m_bus.ready & ~|m_bus.wstrb;

   // remember which slave owes the response
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_sel_q <= 1'b0;
      end else if (rd_acc) begin
         rd_sel_q <= sel;
      end
   end

   // response muxed from the slave that took the read
   assign m_bus.rdata  = rd_sel_q ? tmr_bus.rdata : mem_bus.rdata;
   assign m_bus.rvalid = rd_sel_q ? tmr_bus.rvalid : mem_bus.rvalid;

   // a response only ever comes one cycle after an accepted read
   a_rvalid_after_read : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      m_bus.rvalid |-> $past(rd_acc)
   ) else $error("rvalid without a read accepted the cycle before");

   // the slave not addressed must stay quiet
   a_no_stray_rvalid : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (rd_sel_q ? mem_bus.rvalid : tmr_bus.rvalid) |-> 1'b0
   ) else $error("response from a slave that was not addressed");

endmodule

//--- common/soc_bus_if.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

interface soc_bus_if
   import soc_pkg::*;
();

   // request, held stable until valid and ready meet
   logic                   valid;
   bus_addr_u              addr;
   logic [`SOC_DATA_W-1:0] wdata;
   logic [`SOC_STRB_W-1:0] wstrb;

   // response, rvalid one cycle after an accepted read
   logic                   ready;
   logic [`SOC_DATA_W-1:0] rdata;
   logic                   rvalid;

   modport master (
      output valid, addr, wdata, wstrb,
      input  ready, rdata, rvalid
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output ready, rdata, rvalid
   );

endinterface

//--- common/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

   // field view of a bus address
   // sel picks the slave, word is decoded by the slave itself
   typedef struct packed {
      logic                   sel;
      logic [`SOC_ADDR_W-4:0] word;
      logic [1:0]             byte_off;
   } bus_addr_fields_t;

   // same address word, raw for transport or split into fields
   typedef union packed {
      logic [`SOC_ADDR_W-1:0] raw;
      bus_addr_fields_t       f;
   } bus_addr_u;

   // timer register index, index 3 reads as zero
   typedef enum logic [1:0] {
      LOAD   = 2'd0,
      COUNT  = 2'd1,
      STATUS = 2'd2
   } timer_reg_e;

endpackage

//--- common/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus address is a byte address
`define SOC_ADDR_W 16
`define SOC_DATA_W 32
`define SOC_STRB_W (`SOC_DATA_W / 8)

// internal sram, 256 words
`define SOC_SRAM_WORDS_W 8
`define SOC_SRAM_WORDS (1 << `SOC_SRAM_WORDS_W)

// boot image copied from the external rom
`define SOC_BOOT_WORDS 16
`define SOC_ROM_ADDR_W 4

`endif
